/* project.f */
hdl/corePkg.sv
hdl/ctrlIf.sv
hdl/instDecoder.sv
hdl/immGen.sv
hdl/regFile.sv
hdl/alu.sv
hdl/pcUnit.sv
hdl/dataMem.sv
hdl/singleCycleCore.sv
dv/coreTb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module coreTb -Mdir obj_dir -o coreSim
	./obj_dir/coreSim | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/coreTb.sv */
`timescale 1ns/100ps
`default_nettype none

module coreTb;

	// longest test runs well under 300 cycles
	localparam int maxCycles = 2000;

	logic clk;
	logic rstN;
	corePkg::word_t inst;
	corePkg::word_t pc;
	logic storeEn;
	corePkg::word_t storeAddr;
	corePkg::word_t storeData;
	logic halted;

	corePkg::word_t rom [0:63];
	int nextSlot;
	int cycleCount;

	singleCycleCore singleCycleCore_inst (
		.clk(clk),
		.rstN(rstN),
		.inst(inst),
		.pc(pc),
		.storeEn(storeEn),
		.storeAddr(storeAddr),
		.storeData(storeData),
		.halted(halted)
	);

	// instruction ROM, combinational from pc
	assign inst = rom[pc[7:2]];

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		if (cycleCount >= maxCycles) begin
			$display("timeout: the tests did not finish within %0d cycles", maxCycles);
			$display("Verification failed");
			$fatal(1, "run stopped by cycle limit");
		end else begin
			cycleCount = cycleCount + 1;
		end
	end

	// RV32I encodings, straight from the ISA field layout
	function automatic corePkg::word_t addi(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
	endfunction

	function automatic corePkg::word_t aluReg(input int f7, input int f3, input int rd,
			input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic corePkg::word_t lw(input int rd, input int off, input int rs1);
		return {off[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
	endfunction

	function automatic corePkg::word_t sw(input int rs2, input int off, input int rs1);
		return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
	endfunction

	function automatic corePkg::word_t branch(input int f3, input int rs1, input int rs2,
			input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
			7'b1100011};
	endfunction

	function automatic corePkg::word_t jal(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic corePkg::word_t lui(input int rd, input int imm20);
		return {imm20[19:0], rd[4:0], 7'b0110111};
	endfunction

	// unused slots hold addi x0 with the slot index, harmless
	task automatic fillRom();
		for (int i = 0; i < 64; i++) begin
			rom[i] = addi(0, 0, i);
		end
		nextSlot = 0;
	endtask

	task automatic emit(input corePkg::word_t word);
		rom[nextSlot] = word;
		nextSlot++;
	endtask

	task automatic resetCore();
		@(posedge clk);
		rstN <= 1'b0;
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
	endtask

	task automatic nextStore();
		do begin
			@(negedge clk);
		end while (storeEn !== 1'b1);
	endtask

	task automatic checkWord(input string testName, input corePkg::word_t expected,
			input corePkg::word_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, actual %h", testName, expected, actual);
			$display("Verification failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic checkFlag(input string testName, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %b, actual %b", testName, expected, actual);
			$display("Verification failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic testResetSequence();
		fillRom();
		resetCore();
		checkWord("resetPc", corePkg::resetPc, pc);
		checkFlag("resetHalted", 1'b0, halted);
		for (int i = 1; i <= 6; i++) begin
			@(negedge clk);
			checkWord("sequentialPc", i * 4, pc);
		end
	endtask

	task automatic testAluOps();
		corePkg::word_t a;
		corePkg::word_t b;
		corePkg::word_t expected [0:6];
		a = 25;
		b = -7;
		fillRom();
		emit(addi(1, 0, 25));
		emit(addi(2, 0, -7));
		emit(aluReg(0, 0, 3, 1, 2));
		emit(aluReg(32, 0, 4, 1, 2));
		emit(aluReg(0, 7, 5, 1, 2));
		emit(aluReg(0, 6, 6, 1, 2));
		emit(aluReg(0, 4, 7, 1, 2));
		// negative operand on both sides of slt
		emit(aluReg(0, 2, 8, 2, 1));
		emit(aluReg(0, 2, 9, 1, 2));
		for (int r = 3; r <= 9; r++) begin
			emit(sw(r, (r - 3) * 4, 0));
		end
		expected[0] = a + b;
		expected[1] = a - b;
		expected[2] = a & b;
		expected[3] = a | b;
		expected[4] = a ^ b;
		expected[5] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
		expected[6] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		resetCore();
		for (int i = 0; i < 7; i++) begin
			nextStore();
			checkWord("aluOpsAddr", i * 4, storeAddr);
			checkWord("aluOpsData", expected[i], storeData);
		end
	endtask

	task automatic testMemory();
		corePkg::word_t firstData;
		fillRom();
		emit(addi(1, 0, 32'h5a5));
		emit(sw(1, 40, 0));
		emit(lw(2, 40, 0));
		emit(sw(2, 44, 0));
		resetCore();
		nextStore();
		checkWord("memoryFirstAddr", 40, storeAddr);
		checkWord("memoryFirstData", 32'h5a5, storeData);
		firstData = storeData;
		nextStore();
		checkWord("memorySecondAddr", 44, storeAddr);
		checkWord("memoryLoadBack", firstData, storeData);
	endtask

	// branch is presented now, pc checked one cycle later
	task automatic checkBranch(input string testName, input logic isNe, input int a,
			input int b, input int offset);
		corePkg::word_t branchPc;
		logic taken;
		branchPc = pc;
		taken = isNe ? (a != b) : (a == b);
		@(negedge clk);
		if (taken) begin
			checkWord(testName, branchPc + offset, pc);
		end else begin
			checkWord(testName, branchPc + 32'd4, pc);
		end
	endtask

	task automatic testBranches();
		fillRom();
		emit(addi(1, 0, 3));
		emit(addi(2, 0, 3));
		emit(addi(3, 0, 5));
		emit(branch(0, 1, 2, 12));
		nextSlot = 6;
		emit(branch(0, 1, 3, 12));
		emit(branch(1, 1, 3, 16));
		nextSlot = 11;
		emit(branch(1, 1, 2, -8));
		resetCore();
		repeat (3) @(negedge clk);
		checkWord("branchStart", 12, pc);
		checkBranch("beqTaken", 1'b0, 3, 3, 12);
		checkBranch("beqNotTaken", 1'b0, 3, 5, 12);
		checkBranch("bneTaken", 1'b1, 3, 5, 16);
		checkBranch("bneNotTaken", 1'b1, 3, 3, -8);
	endtask

	task automatic testJalLui();
		corePkg::word_t jalPc;
		corePkg::word_t upper;
		upper = 32'hABCDE;
		fillRom();
		emit(addi(1, 0, 1));
		emit(jal(5, 12));
		nextSlot = 4;
		emit(lui(6, 32'hABCDE));
		emit(sw(5, 48, 0));
		emit(sw(6, 52, 0));
		resetCore();
		@(negedge clk);
		jalPc = pc;
		checkWord("jalPc", 4, jalPc);
		@(negedge clk);
		checkWord("jalTarget", jalPc + 12, pc);
		nextStore();
		checkWord("linkAddr", 48, storeAddr);
		checkWord("linkData", jalPc + 4, storeData);
		nextStore();
		checkWord("luiAddr", 52, storeAddr);
		checkWord("luiData", upper << 12, storeData);
	endtask

	task automatic testHalt();
		corePkg::word_t haltPc;
		fillRom();
		emit(addi(0, 0, 123));
		emit(sw(0, 56, 0));
		// ebreak
		emit(32'h0010_0073);
		emit(sw(0, 60, 0));
		resetCore();
		nextStore();
		checkWord("x0Addr", 56, storeAddr);
		checkWord("x0Zero", 0, storeData);
		@(negedge clk);
		haltPc = pc;
		checkWord("ebreakPc", 8, haltPc);
		checkFlag("haltedBeforeEdge", 1'b0, halted);
		@(negedge clk);
		checkFlag("haltedRise", 1'b1, halted);
		checkWord("haltedRisePc", haltPc, pc);
		// a store now sits at the held pc and must stay blocked
		rom[haltPc[7:2]] = sw(0, 60, 0);
		repeat (6) begin
			@(negedge clk);
			checkFlag("haltedSticky", 1'b1, halted);
			checkWord("haltedPc", haltPc, pc);
			checkFlag("haltedNoStore", 1'b0, storeEn);
		end
	endtask

	initial begin
		cycleCount = 0;
		rstN = 1'b0;
		fillRom();
		testResetSequence();
		testAluOps();
		testMemory();
		testBranches();
		testJalLui();
		testHalt();
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/singleCycleCore.sv */
`timescale 1ns/100ps
`default_nettype none

module singleCycleCore (
	input wire clk,
	input wire rstN,
	input wire corePkg::word_t inst,
	output corePkg::word_t pc,
	output logic storeEn,
	output corePkg::word_t storeAddr,
	output corePkg::word_t storeData,
	output logic halted
);

	corePkg::word_t pcPlus4;
	corePkg::word_t imm;
	corePkg::word_t rs1Data;
	corePkg::word_t rs2Data;
	corePkg::word_t aluB;
	corePkg::word_t aluResult;
	corePkg::word_t memReadData;
	corePkg::word_t wbData;
	logic aluZero;
	logic rfWriteEn;
	logic memWriteEn;
	logic illegal;

	ctrlIf ctrl ();

	instDecoder instDecoder_inst (
		.inst(inst),
		.ctrl(ctrl.decoder),
		.illegal(illegal)
	);

	immGen immGen_inst (
		.inst(inst),
		.ctrl(ctrl.consumer),
		.imm(imm)
	);

	// nothing is written once halted
	assign rfWriteEn = ctrl.regWrite && !halted;
	assign memWriteEn = ctrl.memWrite && !halted;

	regFile regFile_inst (
		.clk(clk),
		.rstN(rstN),
		.writeEn(rfWriteEn),
		.writeAddr(inst[11:7]),
		.writeData(wbData),
		.readAddrA(inst[19:15]),
		.readAddrB(inst[24:20]),
		.readDataA(rs1Data),
		.readDataB(rs2Data)
	);

	assign aluB = ctrl.aluSrcImm ? imm : rs2Data;

	alu alu_inst (
		.opA(rs1Data),
		.opB(aluB),
		.op(ctrl.aluOp),
		.result(aluResult),
		.zero(aluZero)
	);

	pcUnit pcUnit_inst (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl.consumer),
		.imm(imm),
		.aluZero(aluZero),
		.pc(pc),
		.pcPlus4(pcPlus4),
		.halted(halted)
	);

	dataMem dataMem_inst (
		.clk(clk),
		.writeEn(memWriteEn),
		.addr(aluResult),
		.writeData(rs2Data),
		.readData(memReadData)
	);

	always_comb begin
		case (ctrl.wbSel)
			corePkg::wbMem: wbData = memReadData;
			corePkg::wbPc4: wbData = pcPlus4;
			default: wbData = aluResult;
		endcase
	end

	// store path mirrored for observation
	assign storeEn = memWriteEn;
	assign storeAddr = aluResult;
	assign storeData = rs2Data;

	illegalNoWrite: assert property (
		@(posedge clk) disable iff (!rstN)
		illegal |-> !rfWriteEn && !storeEn
	) else $error("illegal instruction reached a write port");

endmodule

`default_nettype wire

/* hdl/dataMem.sv */
`timescale 1ns/100ps
`default_nettype none

module dataMem (
	input wire clk,
	input wire writeEn,
	input wire corePkg::word_t addr,
	input wire corePkg::word_t writeData,
	output corePkg::word_t readData
);

	localparam int indexBits = $clog2(corePkg::dataMemWords);

	corePkg::word_t mem [corePkg::dataMemWords];
	logic [indexBits-1:0] index;

	// word index, byte offset dropped
	assign index = addr[indexBits+1:2];

	always_ff @(posedge clk) begin
		if (writeEn) begin
			mem[index] <= writeData;
		end
	end

	// asynchronous read sees the last stored word
	assign readData = mem[index];

endmodule

`default_nettype wire

/* hdl/pcUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module pcUnit (
	input wire clk,
	input wire rstN,
	ctrlIf.consumer ctrl,
	input wire corePkg::word_t imm,
	input wire aluZero,
	output corePkg::word_t pc,
	output corePkg::word_t pcPlus4,
	output logic halted
);

	logic taken;
	corePkg::word_t pcNext;

	// beq on zero, bne on nonzero
	assign taken = ctrl.jump || (ctrl.branch && (ctrl.branchNe ? !aluZero : aluZero));
	assign pcPlus4 = pc + 32'd4;

	always_comb begin
		if (ctrl.halt || halted) begin
			pcNext = pc;
		end else if (taken) begin
			pcNext = pc + imm;
		end else begin
			pcNext = pcPlus4;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= corePkg::resetPc;
			halted <= 1'b0;
		end else begin
			pc <= pcNext;
			// sticky once ebreak is seen
			halted <= halted || ctrl.halt;
		end
	end

	pcAligned: assert property (
		@(posedge clk) disable iff (!rstN)
		pc[1:0] == 2'b00
	) else $error("pc lost word alignment");

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
	input wire corePkg::word_t opA,
	input wire corePkg::word_t opB,
	input wire corePkg::aluOp_t op,
	output corePkg::word_t result,
	output logic zero
);

	always_comb begin
		case (op)
			corePkg::aluAdd: begin
				result = opA + opB;
			end
			corePkg::aluSub: begin
				result = opA - opB;
			end
			corePkg::aluAnd: begin
				result = opA & opB;
			end
			corePkg::aluOr: begin
				result = opA | opB;
			end
			corePkg::aluXor: begin
				result = opA ^ opB;
			end
			corePkg::aluSlt: begin
				// signed compare
				result = {31'b0, $signed(opA) < $signed(opB)};
			end
			corePkg::aluPassB: begin
				result = opB;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input wire clk,
	input wire rstN,
	input wire writeEn,
	input wire corePkg::regAddr_t writeAddr,
	input wire corePkg::word_t writeData,
	input wire corePkg::regAddr_t readAddrA,
	input wire corePkg::regAddr_t readAddrB,
	output corePkg::word_t readDataA,
	output corePkg::word_t readDataB
);

	corePkg::word_t regs [0:31];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// x0 reads as zero whatever was written
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

	zeroRegHeld: assert property (
		@(posedge clk) disable iff (!rstN)
		(writeEn && writeAddr == '0) |=> (regs[0] == '0)
	) else $error("x0 changed after a write to index zero");

endmodule

`default_nettype wire

/* hdl/immGen.sv */
`timescale 1ns/100ps
`default_nettype none

module immGen (
	input wire corePkg::word_t inst,
	ctrlIf.consumer ctrl,
	output corePkg::word_t imm
);

	always_comb begin
		case (ctrl.immKind)
			corePkg::immI: begin
				imm = {{20{inst[31]}}, inst[31:20]};
			end
			corePkg::immS: begin
				imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			end
			corePkg::immB: begin
				// bit 0 implied zero
				imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			corePkg::immJ: begin
				imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			corePkg::immU: begin
				imm = {inst[31:12], 12'h000};
			end
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/instDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

module instDecoder (
	input wire corePkg::word_t inst,
	ctrlIf.decoder ctrl,
	output logic illegal
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	corePkg::ctrl_t dec;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	always_comb begin
		// safe defaults, nothing written
		dec = '{regWrite: 1'b0, memWrite: 1'b0, branch: 1'b0, branchNe: 1'b0,
			jump: 1'b0, aluSrcImm: 1'b0, aluOp: corePkg::aluAdd,
			immKind: corePkg::immI, wbSel: corePkg::wbAlu, halt: 1'b0};
		illegal = 1'b0;
		case (opcode)
			corePkg::opOp: begin
				dec.regWrite = 1'b1;
				illegal = (funct7 != 7'b0000000);
				case (funct3)
					corePkg::f3AddSub: begin
						// bit 5 of funct7 picks sub
						illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
						dec.aluOp = funct7[5] ? corePkg::aluSub : corePkg::aluAdd;
					end
					corePkg::f3Slt: dec.aluOp = corePkg::aluSlt;
					corePkg::f3Xor: dec.aluOp = corePkg::aluXor;
					corePkg::f3Or: dec.aluOp = corePkg::aluOr;
					corePkg::f3And: dec.aluOp = corePkg::aluAnd;
					default: illegal = 1'b1;
				endcase
			end
			corePkg::opOpImm: begin
				dec.regWrite = 1'b1;
				dec.aluSrcImm = 1'b1;
				illegal = (funct3 != corePkg::f3AddSub);
			end
			corePkg::opLoad: begin
				dec.regWrite = 1'b1;
				dec.aluSrcImm = 1'b1;
				dec.wbSel = corePkg::wbMem;
				illegal = (funct3 != corePkg::f3Word);
			end
			corePkg::opStore: begin
				dec.memWrite = 1'b1;
				dec.aluSrcImm = 1'b1;
				dec.immKind = corePkg::immS;
				illegal = (funct3 != corePkg::f3Word);
			end
			corePkg::opBranch: begin
				// compare by subtraction, zero flag decides
				dec.branch = 1'b1;
				dec.branchNe = (funct3 == corePkg::f3Bne);
				dec.aluOp = corePkg::aluSub;
				dec.immKind = corePkg::immB;
				illegal = (funct3 != corePkg::f3Beq) && (funct3 != corePkg::f3Bne);
			end
			corePkg::opJal: begin
				dec.regWrite = 1'b1;
				dec.jump = 1'b1;
				dec.immKind = corePkg::immJ;
				dec.wbSel = corePkg::wbPc4;
			end
			corePkg::opLui: begin
				dec.regWrite = 1'b1;
				dec.aluSrcImm = 1'b1;
				dec.aluOp = corePkg::aluPassB;
				dec.immKind = corePkg::immU;
			end
			corePkg::opSystem: begin
				dec.halt = (inst == corePkg::instEbreak);
				illegal = (inst != corePkg::instEbreak);
			end
			default: illegal = 1'b1;
		endcase
		// undefined encodings never write
		if (illegal) begin
			dec.regWrite = 1'b0;
			dec.memWrite = 1'b0;
			dec.branch = 1'b0;
			dec.jump = 1'b0;
		end
		assert (!(dec.memWrite && dec.regWrite))
			else $error("decoder enabled register and memory write together");
	end

	assign ctrl.regWrite = dec.regWrite;
	assign ctrl.memWrite = dec.memWrite;
	assign ctrl.branch = dec.branch;
	assign ctrl.branchNe = dec.branchNe;
	assign ctrl.jump = dec.jump;
	assign ctrl.aluSrcImm = dec.aluSrcImm;
	assign ctrl.aluOp = dec.aluOp;
	assign ctrl.immKind = dec.immKind;
	assign ctrl.wbSel = dec.wbSel;
	assign ctrl.halt = dec.halt;

endmodule

`default_nettype wire

/* hdl/ctrlIf.sv */
`timescale 1ns/100ps
`default_nettype none

// decoded control, one driver and several readers
interface ctrlIf;

	logic regWrite;
	logic memWrite;
	logic branch;
	logic branchNe;
	logic jump;
	logic aluSrcImm;
	corePkg::aluOp_t aluOp;
	corePkg::immKind_t immKind;
	corePkg::wbSel_t wbSel;
	logic halt;

	modport decoder (
		output regWrite, memWrite, branch, branchNe, jump, aluSrcImm,
		output aluOp, immKind, wbSel, halt
	);

	modport consumer (
		input regWrite, memWrite, branch, branchNe, jump, aluSrcImm,
		input aluOp, immKind, wbSel, halt
	);

endinterface

`default_nettype wire

/* hdl/corePkg.sv */
`default_nettype none

package corePkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluPassB
	} aluOp_t;

	typedef enum logic [2:0] {
		immI,
		immS,
		immB,
		immJ,
		immU
	} immKind_t;

	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbPc4
	} wbSel_t;

	// decoded control bundle, mirrors ctrlIf
	typedef struct packed {
		logic regWrite;
		logic memWrite;
		logic branch;
		logic branchNe;
		logic jump;
		logic aluSrcImm;
		aluOp_t aluOp;
		immKind_t immKind;
		wbSel_t wbSel;
		logic halt;
	} ctrl_t;

	// major opcodes
	localparam logic [6:0] opOp = 7'b0110011;
	localparam logic [6:0] opOpImm = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opSystem = 7'b1110011;

	// funct3 codes used by the subset
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3Xor = 3'b100;
	localparam logic [2:0] f3Or = 3'b110;
	localparam logic [2:0] f3And = 3'b111;
	localparam logic [2:0] f3Word = 3'b010;
	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;

	// full ebreak encoding
	localparam word_t instEbreak = 32'h0010_0073;

	localparam int dataMemWords = 64;
	localparam word_t resetPc = 32'h0000_0000;

endpackage

`default_nettype wire
